/* src/ex_op_pkg.sv */
// Execute stage operation encodings
package ex_op_pkg;

  ////////////////////
  // ALU operators
  ////////////////////

  typedef enum logic [3:0] {
    ALU_ADD = 4'h0,
    ALU_SUB = 4'h1,
    ALU_AND = 4'h2,
    ALU_OR  = 4'h3,
    ALU_XOR = 4'h4,
    ALU_SLL = 4'h5,
    ALU_SRL = 4'h6,
    ALU_SRA = 4'h7,
    // Compares, result is a single bit
    ALU_EQ  = 4'h8,
    ALU_NE  = 4'h9,
    ALU_LT  = 4'ha,
    ALU_LTU = 4'hb,
    ALU_GE  = 4'hc,
    ALU_GEU = 4'hd
  } alu_op_e;

  ////////////////////
  // Quantizer
  ////////////////////

  // Output levels of the 2-bit mode
  localparam int QNT_LEVELS = 4;
  // Byte distance between stored thresholds
  localparam int QNT_STEP   = 4;

endpackage

/* src/ex_bus_pkg.sv */
// Execute stage data and bus types
package ex_bus_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand and result word
  localparam int WORD_W     = 32;
  // Register file address
  localparam int REG_ADDR_W = 5;
  // Wishbone byte address
  localparam int WB_ADDR_W  = 32;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [WB_ADDR_W-1:0]  wb_addr_t;

endpackage

/* src/ex_alu.sv */
// Single-cycle integer ALU
`timescale 1ns/1ps

module ex_alu (
  input  ex_op_pkg::alu_op_e operator_i,
  input  ex_bus_pkg::word_t  operand_a_i,
  input  ex_bus_pkg::word_t  operand_b_i,
  output ex_bus_pkg::word_t  result_o,
  output logic               cmp_result_o
);

  logic        is_signed;
  logic [32:0] diff;
  logic        lt;
  logic        eq;
  logic [4:0]  shamt;

  // Signed compare only for LT and GE
  assign is_signed = (operator_i == ex_op_pkg::ALU_LT) ||
                     (operator_i == ex_op_pkg::ALU_GE);

  // Shared subtractor, one extra bit so the top bit is the sign
  assign diff = {is_signed & operand_a_i[31], operand_a_i} -
                {is_signed & operand_b_i[31], operand_b_i};

  assign lt    = diff[32];
  assign eq    = (operand_a_i == operand_b_i);
  // RV32 shifts use the low 5 bits only
  assign shamt = operand_b_i[4:0];

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;
    case (operator_i)
      ex_op_pkg::ALU_ADD: result_o = operand_a_i + operand_b_i;
      ex_op_pkg::ALU_SUB: result_o = diff[31:0];
      ex_op_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_op_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_op_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_op_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_op_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      ex_op_pkg::ALU_SRA: result_o = $signed(operand_a_i) >>> shamt;
      // Compares drive the branch decision too
      ex_op_pkg::ALU_EQ:  cmp_result_o = eq;
      ex_op_pkg::ALU_NE:  cmp_result_o = ~eq;
      ex_op_pkg::ALU_LT,
      ex_op_pkg::ALU_LTU: cmp_result_o = lt;
      ex_op_pkg::ALU_GE,
      ex_op_pkg::ALU_GEU: cmp_result_o = ~lt;
      default: begin
        result_o     = '0;
        cmp_result_o = 1'b0;
      end
    endcase
    // Compare bit lands in bit 0 of the result
    if (operator_i >= ex_op_pkg::ALU_EQ) begin
      result_o = ex_bus_pkg::word_t'(cmp_result_o);
    end
  end

endmodule

/* src/ex_mult.sv */
// Digit-serial multiplier
`timescale 1ns/1ps

module ex_mult #(
  parameter int MULT_DIGIT_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  ex_bus_pkg::word_t op_a_i,
  input  ex_bus_pkg::word_t op_b_i,
  input  logic              ex_ready_i,
  output ex_bus_pkg::word_t result_o,
  output logic              ready_o
);

  // One digit of op_b per cycle
  localparam int NUM_DIGITS = ex_bus_pkg::WORD_W / MULT_DIGIT_W;
  localparam int CNT_W      = (NUM_DIGITS > 2) ? $clog2(NUM_DIGITS) : 1;

  typedef enum logic [1:0] {M_IDLE, M_RUN, M_DONE} mult_state_e;

  mult_state_e       state_q;
  logic [CNT_W-1:0]  cnt_q;
  ex_bus_pkg::word_t acc_q;
  ex_bus_pkg::word_t mcand_q;
  ex_bus_pkg::word_t mplier_q;
  ex_bus_pkg::word_t pp_first;
  ex_bus_pkg::word_t pp_next;

  // Partial products, low word only
  assign pp_first = op_a_i * ex_bus_pkg::word_t'(op_b_i[MULT_DIGIT_W-1:0]);
  assign pp_next  = mcand_q * ex_bus_pkg::word_t'(mplier_q[MULT_DIGIT_W-1:0]);

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= M_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        M_IDLE: if (enable_i) begin
          // Digit 0 is taken straight from the inputs
          state_q <= M_RUN;
          cnt_q   <= CNT_W'(1);
        end
        M_RUN: if (cnt_q == CNT_W'(NUM_DIGITS - 1)) begin
          state_q <= M_DONE;
        end else begin
          cnt_q <= cnt_q + CNT_W'(1);
        end
        // Hold the product until it retires
        M_DONE: if (ex_ready_i) state_q <= M_IDLE;
        default: state_q <= M_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk) begin
    if (state_q == M_IDLE && enable_i) begin
      acc_q    <= pp_first;
      mcand_q  <= op_a_i << MULT_DIGIT_W;
      mplier_q <= op_b_i >> MULT_DIGIT_W;
    end else if (state_q == M_RUN) begin
      // Multiplicand shifts left so each digit lands in place
      acc_q    <= acc_q + pp_next;
      mcand_q  <= mcand_q << MULT_DIGIT_W;
      mplier_q <= mplier_q >> MULT_DIGIT_W;
    end
  end

  assign result_o = acc_q;
  // Low while a new operation starts or runs
  assign ready_o  = (state_q == M_DONE) | ((state_q == M_IDLE) & ~enable_i);

endmodule

/* src/ex_qnt.sv */
// 2-bit threshold quantizer
`timescale 1ns/1ps

module ex_qnt (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable_i,
  input  ex_bus_pkg::word_t    value_i,
  input  ex_bus_pkg::wb_addr_t base_i,
  input  logic                 ex_ready_i,
  // Wishbone classic master, reads only
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output ex_bus_pkg::wb_addr_t wb_adr_o,
  input  logic                 wb_ack_i,
  input  ex_bus_pkg::word_t    wb_dat_i,
  output ex_bus_pkg::word_t    result_o,
  output logic                 ready_o
);

  localparam int LVL_W = $clog2(ex_op_pkg::QNT_LEVELS);

  // Offsets of the middle and upper thresholds
  localparam ex_bus_pkg::wb_addr_t MID_OFS = ex_bus_pkg::wb_addr_t'(ex_op_pkg::QNT_STEP);
  localparam ex_bus_pkg::wb_addr_t TOP_OFS = ex_bus_pkg::wb_addr_t'(2 * ex_op_pkg::QNT_STEP);

  typedef enum logic [2:0] {
    Q_IDLE,
    Q_RD1,
    Q_GAP,
    Q_RD2,
    Q_DONE
  } qnt_state_e;

  qnt_state_e       state_q;
  logic             ge_mid_q;
  logic             ge_sec_q;
  logic             ge_thr;
  logic [LVL_W-1:0] level;

  // Signed compare against the word on the bus
  assign ge_thr = $signed(value_i) >= $signed(wb_dat_i);

  ////////////////////
  // Search FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= Q_IDLE;
    end else begin
      case (state_q)
        Q_IDLE: if (enable_i) state_q <= Q_RD1;
        Q_RD1:  if (wb_ack_i) state_q <= Q_GAP;
        // Bus idle for one cycle between reads
        Q_GAP:  state_q <= Q_RD2;
        Q_RD2:  if (wb_ack_i) state_q <= Q_DONE;
        Q_DONE: if (ex_ready_i) state_q <= Q_IDLE;
        default: state_q <= Q_IDLE;
      endcase
    end
  end

  // Compare results, captured on ack
  always_ff @(posedge clk) begin
    if (state_q == Q_RD1 && wb_ack_i) begin
      ge_mid_q <= ge_thr;
    end
    if (state_q == Q_RD2 && wb_ack_i) begin
      ge_sec_q <= ge_thr;
    end
  end

  ////////////////////
  // Bus and result
  ////////////////////

  assign wb_cyc_o = (state_q == Q_RD1) | (state_q == Q_RD2);
  assign wb_stb_o = wb_cyc_o;

  // Middle first, then upper or lower by the first compare
  always_comb begin
    if (state_q == Q_RD1) begin
      wb_adr_o = base_i + MID_OFS;
    end else if (ge_mid_q) begin
      wb_adr_o = base_i + TOP_OFS;
    end else begin
      wb_adr_o = base_i;
    end
  end

  // Above mid gives 2 plus upper hit, else lower hit
  assign level    = LVL_W'({ge_mid_q, ge_sec_q});
  assign result_o = ex_bus_pkg::word_t'(level);
  assign ready_o  = (state_q == Q_DONE) | ((state_q == Q_IDLE) & ~enable_i);

endmodule

/* src/ex_writeback.sv */
// Result select and EX/WB register
`timescale 1ns/1ps

module ex_writeback (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  qnt_en_i,
  input  ex_bus_pkg::word_t     alu_result_i,
  input  ex_bus_pkg::word_t     mult_result_i,
  input  ex_bus_pkg::word_t     qnt_result_i,
  input  logic                  mult_ready_i,
  input  logic                  qnt_ready_i,
  input  logic                  regfile_we_i,
  input  ex_bus_pkg::reg_addr_t regfile_waddr_i,
  input  logic                  wb_ready_i,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  regfile_we_wb_o,
  output ex_bus_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_bus_pkg::word_t     regfile_wdata_wb_o
);

  logic              any_en;
  logic              unit_done;
  logic              wb_free;
  ex_bus_pkg::word_t result;

  assign any_en    = alu_en_i | mult_en_i | qnt_en_i;
  // ALU is always done in the cycle it is presented
  assign unit_done = alu_en_i | (mult_en_i & mult_ready_i) | (qnt_en_i & qnt_ready_i);
  // Slot empty or draining this edge
  assign wb_free   = ~regfile_we_wb_o | wb_ready_i;

  assign ex_valid_o = unit_done & wb_free;
  assign ex_ready_o = any_en ? ex_valid_o : 1'b1;

  // At most one enable is high
  always_comb begin
    if (mult_en_i) begin
      result = mult_result_i;
    end else if (qnt_en_i) begin
      result = qnt_result_i;
    end else begin
      result = alu_result_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= regfile_we_i;
    end else if (wb_ready_i) begin
      // WB took the old entry, nothing new behind it
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
      regfile_wdata_wb_o <= result;
    end
  end

endmodule

/* src/ex_stage.sv */
// Reduced execute stage top
`timescale 1ns/1ps

module ex_stage #(
  parameter int MULT_DIGIT_W = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // ALU operation
  input  logic                  alu_en_i,
  input  ex_op_pkg::alu_op_e    alu_operator_i,
  input  ex_bus_pkg::word_t     alu_operand_a_i,
  input  ex_bus_pkg::word_t     alu_operand_b_i,
  // Multiply operation
  input  logic                  mult_en_i,
  input  ex_bus_pkg::word_t     mult_operand_a_i,
  input  ex_bus_pkg::word_t     mult_operand_b_i,
  // Quantize operation
  input  logic                  qnt_en_i,
  input  ex_bus_pkg::word_t     qnt_value_i,
  input  ex_bus_pkg::wb_addr_t  qnt_base_i,
  // Destination register
  input  logic                  regfile_we_i,
  input  ex_bus_pkg::reg_addr_t regfile_waddr_i,
  input  logic                  wb_ready_i,
  // Threshold memory
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output ex_bus_pkg::wb_addr_t  wb_adr_o,
  input  logic                  wb_ack_i,
  input  ex_bus_pkg::word_t     wb_dat_i,
  // To fetch and decode
  output logic                  branch_decision_o,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  // To WB
  output logic                  regfile_we_wb_o,
  output ex_bus_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_bus_pkg::word_t     regfile_wdata_wb_o
);

  ex_bus_pkg::word_t alu_result;
  ex_bus_pkg::word_t mult_result;
  ex_bus_pkg::word_t qnt_result;
  logic              mult_ready;
  logic              qnt_ready;

  ////////////////////
  // Units
  ////////////////////

  // Compare bit is the branch decision
  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult #(
    .MULT_DIGIT_W (MULT_DIGIT_W)
  ) u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (mult_en_i),
    .op_a_i     (mult_operand_a_i),
    .op_b_i     (mult_operand_b_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ex_qnt u_qnt (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable_i   (qnt_en_i),
    .value_i    (qnt_value_i),
    .base_i     (qnt_base_i),
    .ex_ready_i (ex_ready_o),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .wb_ack_i   (wb_ack_i),
    .wb_dat_i   (wb_dat_i),
    .result_o   (qnt_result),
    .ready_o    (qnt_ready)
  );

  // Handshake and pipeline register
  ex_writeback u_writeback (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_en_i           (alu_en_i),
    .mult_en_i          (mult_en_i),
    .qnt_en_i           (qnt_en_i),
    .alu_result_i       (alu_result),
    .mult_result_i      (mult_result),
    .qnt_result_i       (qnt_result),
    .mult_ready_i       (mult_ready),
    .qnt_ready_i        (qnt_ready),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .wb_ready_i         (wb_ready_i),
    .ex_ready_o         (ex_ready_o),
    .ex_valid_o         (ex_valid_o),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

endmodule

/* dv/ex_stage_tests.svh */
// Execute stage directed tests

////////////////////
// Helpers
////////////////////

// Standard RV32 results with compares as 0 or 1
function automatic ex_bus_pkg::word_t alu_expected(input ex_op_pkg::alu_op_e op,
                                                   input ex_bus_pkg::word_t a,
                                                   input ex_bus_pkg::word_t b);
  case (op)
    ex_op_pkg::ALU_ADD: return a + b;
    ex_op_pkg::ALU_SUB: return a - b;
    ex_op_pkg::ALU_AND: return a & b;
    ex_op_pkg::ALU_OR:  return a | b;
    ex_op_pkg::ALU_XOR: return a ^ b;
    ex_op_pkg::ALU_SLL: return a << b[4:0];
    ex_op_pkg::ALU_SRL: return a >> b[4:0];
    ex_op_pkg::ALU_SRA: return $signed(a) >>> b[4:0];
    ex_op_pkg::ALU_EQ:  return {31'b0, a == b};
    ex_op_pkg::ALU_NE:  return {31'b0, a != b};
    ex_op_pkg::ALU_LT:  return {31'b0, $signed(a) < $signed(b)};
    ex_op_pkg::ALU_LTU: return {31'b0, a < b};
    ex_op_pkg::ALU_GE:  return {31'b0, $signed(a) >= $signed(b)};
    ex_op_pkg::ALU_GEU: return {31'b0, a >= b};
    default:            return '0;
  endcase
endfunction

task automatic issue_alu(input ex_op_pkg::alu_op_e op, input ex_bus_pkg::word_t a,
                         input ex_bus_pkg::word_t b, input ex_bus_pkg::reg_addr_t rd);
  @(posedge clk);
  alu_en_i        <= 1'b1;
  alu_operator_i  <= op;
  alu_operand_a_i <= a;
  alu_operand_b_i <= b;
  regfile_we_i    <= 1'b1;
  regfile_waddr_i <= rd;
endtask

// Cycles from the issue edge to the first valid cycle
task automatic wait_valid(output int lat);
  lat = 0;
  @(negedge clk);
  while (!ex_valid_o && lat < OP_LIMIT) begin
    // Decode must hold the operation while EX is busy
    check_bit("ex_ready_o", ex_ready_o, 1'b0);
    @(negedge clk);
    lat++;
  end
  if (!ex_valid_o) begin
    $display("error: ex_valid_o did not rise within %0d cycles", OP_LIMIT);
    err_count++;
  end else begin
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
  end
endtask

// Retire edge and then the EX/WB register holds the result
task automatic retire_and_check(input ex_bus_pkg::word_t exp_data,
                                input ex_bus_pkg::reg_addr_t exp_rd);
  @(posedge clk);
  alu_en_i  <= 1'b0;
  mult_en_i <= 1'b0;
  qnt_en_i  <= 1'b0;
  @(negedge clk);
  check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
  check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, exp_rd);
  check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, exp_data);
endtask

////////////////////
// Tests
////////////////////

task automatic reset_outputs();
  int errs;
  errs = err_count;
  @(negedge clk);
  check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b0);
  check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
  check_bit("wb_stb_o", wb_stb_o, 1'b0);
  check_bit("ex_ready_o", ex_ready_o, 1'b1);
  check_bit("ex_valid_o", ex_valid_o, 1'b0);
  report_test("reset", errs);
endtask

task automatic every_alu_op();
  ex_op_pkg::alu_op_e    op;
  ex_bus_pkg::word_t     a;
  ex_bus_pkg::word_t     b;
  ex_bus_pkg::word_t     exp;
  ex_bus_pkg::reg_addr_t rd;
  int                    lat;
  int                    errs;
  errs = err_count;
  op = op.first();
  forever begin
    for (int rep = 0; rep < 3; rep++) begin
      a = $random(seed);
      // First pass with equal operands hits EQ and GE
      b = (rep == 0) ? a : ex_bus_pkg::word_t'($random(seed));
      rd = ex_bus_pkg::reg_addr_t'($random(seed));
      exp = alu_expected(op, a, b);
      issue_alu(op, a, b, rd);
      wait_valid(lat);
      if (lat != 0) begin
        $display("error: %s not valid in its issue cycle", op.name());
        err_count++;
      end
      if (op >= ex_op_pkg::ALU_EQ) begin
        check_bit("branch_decision_o", branch_decision_o, exp[0]);
      end
      retire_and_check(exp, rd);
    end
    if (op == op.last()) break;
    op = op.next();
  end
  report_test("alu", errs);
endtask

task automatic mult_products();
  // Zero, all ones and most negative
  ex_bus_pkg::word_t     edge_a [5] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
                                        32'h8000_0000, 32'hffff_ffff};
  ex_bus_pkg::word_t     edge_b [5] = '{32'h1234_5678, 32'hffff_ffff, 32'hffff_ffff,
                                        32'h8000_0000, 32'h0000_0002};
  ex_bus_pkg::word_t     a;
  ex_bus_pkg::word_t     b;
  ex_bus_pkg::reg_addr_t rd;
  logic [63:0]           prod;
  int                    lat;
  int                    errs;
  errs = err_count;
  for (int i = 0; i < 9; i++) begin
    a = (i < 5) ? edge_a[i] : ex_bus_pkg::word_t'($random(seed));
    b = (i < 5) ? edge_b[i] : ex_bus_pkg::word_t'($random(seed));
    rd = ex_bus_pkg::reg_addr_t'($random(seed));
    prod = {32'h0, a} * {32'h0, b};
    @(posedge clk);
    mult_en_i        <= 1'b1;
    mult_operand_a_i <= a;
    mult_operand_b_i <= b;
    regfile_we_i     <= 1'b1;
    regfile_waddr_i  <= rd;
    wait_valid(lat);
    if (lat != 32 / MULT_DIGIT_W) begin
      $display("error: multiply took %0d cycles, expected %0d", lat, 32 / MULT_DIGIT_W);
      err_count++;
    end
    retire_and_check(prod[31:0], rd);
  end
  report_test("mult", errs);
endtask

task automatic quantize_one(input ex_bus_pkg::wb_addr_t base, input ex_bus_pkg::word_t v,
                            input ex_bus_pkg::word_t thr [ex_op_pkg::QNT_LEVELS-1]);
  ex_bus_pkg::wb_addr_t  second;
  ex_bus_pkg::reg_addr_t rd;
  int                    lvl;
  int                    lat;
  // Store thresholds at base, base+4 and base+8
  for (int k = 0; k < ex_op_pkg::QNT_LEVELS - 1; k++) begin
    mem[base[7:2] + k] = thr[k];
  end
  lvl = 0;
  for (int k = 0; k < ex_op_pkg::QNT_LEVELS - 1; k++) begin
    if ($signed(thr[k]) <= $signed(v)) lvl++;
  end
  second = ($signed(v) >= $signed(thr[1])) ?
           base + ex_bus_pkg::wb_addr_t'(2 * ex_op_pkg::QNT_STEP) : base;
  rd = ex_bus_pkg::reg_addr_t'($random(seed));
  rd_log.delete();
  @(posedge clk);
  qnt_en_i        <= 1'b1;
  qnt_value_i     <= v;
  qnt_base_i      <= base;
  regfile_we_i    <= 1'b1;
  regfile_waddr_i <= rd;
  wait_valid(lat);
  retire_and_check(ex_bus_pkg::word_t'(lvl), rd);
  if (rd_log.size() != 2) begin
    $display("error: quantize of 0x%h made %0d reads instead of 2", v, rd_log.size());
    err_count++;
  end else begin
    check_bus_addr("wb_adr_o", rd_log[0], base + ex_bus_pkg::wb_addr_t'(ex_op_pkg::QNT_STEP));
    check_bus_addr("wb_adr_o", rd_log[1], second);
  end
endtask

task automatic threshold_levels();
  ex_bus_pkg::word_t thr_a [ex_op_pkg::QNT_LEVELS-1] = '{-100, 0, 100};
  ex_bus_pkg::word_t thr_b [ex_op_pkg::QNT_LEVELS-1] = '{-5, 7, 1000};
  // Below, on and above each threshold and both extremes
  ex_bus_pkg::word_t vals_a [9] = '{-101, -100, -1, 0, 50, 100, 1000,
                                    32'h8000_0000, 32'h7fff_ffff};
  ex_bus_pkg::word_t vals_b [4] = '{-6, 7, 999, 1000};
  int                errs;
  errs = err_count;
  foreach (vals_a[i]) quantize_one(32'h40, vals_a[i], thr_a);
  foreach (vals_b[i]) quantize_one(32'h80, vals_b[i], thr_b);
  report_test("quantize", errs);
endtask

task automatic stall_and_release();
  ex_bus_pkg::word_t a1;
  ex_bus_pkg::word_t b1;
  ex_bus_pkg::word_t a2;
  ex_bus_pkg::word_t b2;
  int                lat;
  int                errs;
  errs = err_count;
  a1 = $random(seed);
  b1 = $random(seed);
  a2 = $random(seed);
  b2 = $random(seed);
  @(posedge clk);
  wb_ready_i <= 1'b0;
  issue_alu(ex_op_pkg::ALU_ADD, a1, b1, 5'd3);
  wait_valid(lat);
  // Second operation follows on the retire edge
  @(posedge clk);
  alu_operator_i  <= ex_op_pkg::ALU_XOR;
  alu_operand_a_i <= a2;
  alu_operand_b_i <= b2;
  regfile_waddr_i <= 5'd17;
  repeat (3) begin
    @(negedge clk);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b0);
    check_bit("regfile_we_wb_o", regfile_we_wb_o, 1'b1);
    check_addr("regfile_waddr_wb_o", regfile_waddr_wb_o, 5'd3);
    check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, a1 + b1);
  end
  @(posedge clk);
  wb_ready_i <= 1'b1;
  wait_valid(lat);
  // Slot drains this cycle so the second operation is valid at once
  if (lat != 0) begin
    $display("error: second operation not valid once WB was ready");
    err_count++;
  end
  // First result still shown until WB takes it
  check_word("regfile_wdata_wb_o", regfile_wdata_wb_o, a1 + b1);
  retire_and_check(a2 ^ b2, 5'd17);
  report_test("back_pressure", errs);
endtask

/* dv/ex_stage_tb.sv */
// Execute stage testbench
`timescale 1ns/1ps

module ex_stage_tb;

  localparam int MULT_DIGIT_W = 8;
  localparam int CLK_PERIOD   = 10;
  localparam int NUM_TESTS    = 5;
  // Cycle bound for a single operation
  localparam int OP_LIMIT     = 50;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  alu_en_i;
  ex_op_pkg::alu_op_e    alu_operator_i;
  ex_bus_pkg::word_t     alu_operand_a_i;
  ex_bus_pkg::word_t     alu_operand_b_i;
  logic                  mult_en_i;
  ex_bus_pkg::word_t     mult_operand_a_i;
  ex_bus_pkg::word_t     mult_operand_b_i;
  logic                  qnt_en_i;
  ex_bus_pkg::word_t     qnt_value_i;
  ex_bus_pkg::wb_addr_t  qnt_base_i;
  logic                  regfile_we_i;
  ex_bus_pkg::reg_addr_t regfile_waddr_i;
  logic                  wb_ready_i;
  logic                  wb_cyc_o;
  logic                  wb_stb_o;
  ex_bus_pkg::wb_addr_t  wb_adr_o;
  logic                  wb_ack_i;
  ex_bus_pkg::word_t     wb_dat_i;
  logic                  branch_decision_o;
  logic                  ex_ready_o;
  logic                  ex_valid_o;
  logic                  regfile_we_wb_o;
  ex_bus_pkg::reg_addr_t regfile_waddr_wb_o;
  ex_bus_pkg::word_t     regfile_wdata_wb_o;

  integer seed = 32'h4a63_122c;
  int     err_count  = 0;
  int     pass_tests = 0;
  int     fail_tests = 0;

  // 10 ns period
  always #(CLK_PERIOD / 2) clk = ~clk;

  ex_stage #(.MULT_DIGIT_W(MULT_DIGIT_W)) UUT (.*);

  ////////////////////
  // Wishbone memory
  ////////////////////

  ex_bus_pkg::word_t    mem [64];
  int                   ack_wait;
  int                   ack_delay;
  ex_bus_pkg::wb_addr_t rd_log [$];

  // Each word starts as its own byte address with a tag
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5a00_0000 | (i * 4);
    end
  end

  // Ack after 0 to 3 extra cycles and hold it for one cycle
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_i  <= 1'b0;
      wb_dat_i  <= '0;
      ack_wait  <= 0;
      ack_delay <= 0;
    end else if (wb_ack_i) begin
      wb_ack_i  <= 1'b0;
      ack_wait  <= 0;
      ack_delay <= $unsigned($random(seed)) % 4;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (ack_wait == ack_delay) begin
        wb_ack_i <= 1'b1;
        wb_dat_i <= mem[wb_adr_o[7:2]];
      end else begin
        ack_wait <= ack_wait + 1;
      end
    end
  end

  // One entry per finished read
  always @(negedge clk) begin
    if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
      rd_log.push_back(wb_adr_o);
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input ex_bus_pkg::word_t act,
                            input ex_bus_pkg::word_t exp);
    if (act !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input ex_bus_pkg::reg_addr_t act,
                            input ex_bus_pkg::reg_addr_t exp);
    if (act !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
      err_count++;
    end
  endtask

  task automatic check_bus_addr(input string name, input ex_bus_pkg::wb_addr_t act,
                                input ex_bus_pkg::wb_addr_t exp);
    if (act !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, act, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_tests++;
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  `include "ex_stage_tests.svh"

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    rst_n            <= 1'b0;
    alu_en_i         <= 1'b0;
    alu_operator_i   <= ex_op_pkg::ALU_ADD;
    alu_operand_a_i  <= '0;
    alu_operand_b_i  <= '0;
    mult_en_i        <= 1'b0;
    mult_operand_a_i <= '0;
    mult_operand_b_i <= '0;
    qnt_en_i         <= 1'b0;
    qnt_value_i      <= '0;
    qnt_base_i       <= '0;
    regfile_we_i     <= 1'b0;
    regfile_waddr_i  <= '0;
    wb_ready_i       <= 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    reset_outputs();
    every_alu_op();
    mult_products();
    threshold_levels();
    stall_and_release();
    $display("tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (err_count == 0 && fail_tests == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d ns", NUM_TESTS * 200 * CLK_PERIOD);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+dv
src/ex_op_pkg.sv
src/ex_bus_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_qnt.sv
src/ex_writeback.sv
src/ex_stage.sv
dv/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --top-module ex_stage_tb -Mdir obj_dir -o sim -f list.f \
  && ./obj_dir/sim | tee sim.log \
  && grep -q "^SIMULATION PASSED$" sim.log \
  && echo "run.sh: pass" \
  || { echo "run.sh: fail"; exit 1; }
